// File: cache_pipe_top.f
verilog/cache_pkg.sv
verilog/set_if.sv
verilog/line_ram.sv
verilog/hit_detect.sv
verilog/victim_select.sv
verilog/set_stage.sv
verilog/data_stage.sv
verilog/cache_pipe_top.sv
verif/cache_pipe_props.sv
verif/cache_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status follows the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module cache_pipe_tb \
  -f cache_pipe_top.f \
  --Mdir obj_dir -o cache_pipe_sim
./obj_dir/cache_pipe_sim

// File: verif/cache_pipe_props.sv
`default_nettype none

module cache_pipe_props (
  input wire                         clk,
  input wire                         rst,
  input wire                         rsp_valid,
  input var  cache_pkg::lu_result_t  rsp_result,
  input wire                         fm_valid,
  input var  cache_pkg::fm_op_t      fm_op
);
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  // outputs stay quiet while in reset and for two edges after it
  assert property (@(posedge clk) rst |=> !rsp_valid && !fm_valid)
    else $error("output valid in the cycle after a reset cycle");
  assert property (@(posedge clk) $past(rst) |=> !rsp_valid && !fm_valid)
    else $error("output valid in the second cycle after reset");

  // far-memory traffic only rides along with a response
  assert property (@(posedge clk) disable iff (rst) fm_valid |-> rsp_valid)
    else $error("far-memory request without a response");

  // a fill may evict, never request another fill
  assert property (@(posedge clk) disable iff (rst)
                   (rsp_valid && rsp_result == FILL) |-> !(fm_valid && fm_op == FILL_REQ_OP))
    else $error("fill response came with a fill request");

endmodule

bind cache_pipe_top cache_pipe_props u_props (
  .clk        (clk),
  .rst        (rst),
  .rsp_valid  (rsp_valid),
  .rsp_result (rsp_result),
  .fm_valid   (fm_valid),
  .fm_op      (fm_op)
);

`default_nettype wire

// File: verif/cache_pipe_tb.sv
`default_nettype none

module cache_pipe_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  localparam int                   NUM_LOOKUPS = 2000;
  localparam int                   MAX_CYCLES  = 2 * NUM_LOOKUPS + 50;
  localparam logic [31:0]          SEED        = 32'hd88e;
  localparam logic [SET_WIDTH-1:0] SET_A       = 4'h3;      // only two sets in use
  localparam logic [SET_WIDTH-1:0] SET_B       = 4'hb;
  localparam logic [TAG_WIDTH-1:0] TAG_BASE    = 24'h4a7100; // eight tags from here

  // one expected response with its far-memory side
  typedef struct packed {
    lu_op_t                op;
    lu_result_t            result;
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    line_t                 line;
    logic                  fm_valid;
    fm_op_t                fm_op;
    logic [ADDR_WIDTH-1:0] fm_addr;
    line_t                 fm_data;
    int                    due;       // cycle count when it must show up
  } exp_t;

  logic clk = 1'b0;
  logic rst;
  logic lu_valid, lu_fill_modified;
  lu_op_t lu_op;
  logic [ID_WIDTH-1:0] lu_id;
  logic [ADDR_WIDTH-1:0] lu_addr;
  logic [WORD_WIDTH-1:0] lu_wdata;
  logic [BE_WIDTH-1:0] lu_byte_en;
  line_t lu_fill_line;
  logic rsp_valid, fm_valid;
  lu_op_t rsp_op;
  lu_result_t rsp_result;
  logic [ID_WIDTH-1:0] rsp_id, fm_id;
  logic [ADDR_WIDTH-1:0] rsp_addr, fm_addr;
  line_t rsp_line, fm_data;
  fm_op_t fm_op;

  // serial cache model that starts from the same reset state as the DUT arrays
  way_vec_t             m_valid [NUM_SETS];
  way_vec_t             m_mru   [NUM_SETS];
  way_vec_t             m_mod   [NUM_SETS];
  logic [TAG_WIDTH-1:0] m_tag   [NUM_SETS][NUM_WAYS];
  line_t                m_line  [NUM_SETS][NUM_WAYS];

  exp_t exp_q[$];
  int cycle_cnt = 0;
  int rsp_cnt = 0;
  int n_hit = 0, n_miss = 0, n_fill = 0, n_evict = 0;
  logic [ID_WIDTH-1:0] next_id = '0;

  cache_pipe_top u_cache_pipe_top (.*);

  always #50 clk = ~clk;   // 100 ns period

  // ==========================================================================
  // reference model
  // ==========================================================================
  function automatic int find_way(logic [SET_WIDTH-1:0] s, logic [TAG_WIDTH-1:0] t);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) return w;
    end
    return -1;   // absent
  endfunction

  // free way first and then the lowest non-MRU one
  function automatic int pick_victim(logic [SET_WIDTH-1:0] s);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_valid[s][w]) return w;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_mru[s][w]) return w;
    end
    return 0;
  endfunction

  task automatic mark_mru(logic [SET_WIDTH-1:0] s, int w);
    m_mru[s][w] = 1'b1;
    if (&m_mru[s]) begin
      m_mru[s]    = '0;   // all MRU so only the newest stays set
      m_mru[s][w] = 1'b1;
    end
  endtask

  task automatic issue_lookup();
    logic [SET_WIDTH-1:0]    s;
    logic [TAG_WIDTH-1:0]    t;
    logic [OFFSET_WIDTH-1:0] off;
    lu_op_t                  op;
    logic [WORD_WIDTH-1:0]   wdata;
    logic [BE_WIDTH-1:0]     be;
    line_t                   fline;
    logic                    fmod;
    int                      hw;
    int                      vw;
    exp_t                    e;
    s     = ($urandom % 2 == 0) ? SET_A : SET_B;
    t     = TAG_BASE + TAG_WIDTH'($urandom % 8);
    off   = OFFSET_WIDTH'($urandom);
    wdata = $urandom;
    be    = BE_WIDTH'($urandom);
    fline = {$urandom, $urandom, $urandom, $urandom};
    fmod  = 1'($urandom);
    case ($urandom % 3)
      0:       op = RD_LU;
      1:       op = WR_LU;
      default: op = FILL_LU;
    endcase
    hw = find_way(s, t);
    if (op == FILL_LU && hw >= 0) op = RD_LU;   // fills only for absent lines
    e      = '0;
    e.op   = op;
    e.id   = next_id;
    e.addr = {t, s, off};
    e.due  = cycle_cnt + 4;                      // sampled at the next edge and out two later
    if (op == FILL_LU) begin
      vw       = pick_victim(s);
      e.result = FILL;
      e.line   = fline;
      n_fill++;
      if (m_valid[s][vw] && m_mod[s][vw]) begin
        e.fm_valid = 1'b1;
        e.fm_op    = DIRTY_EVICT_OP;
        e.fm_addr  = {m_tag[s][vw], s, {OFFSET_WIDTH{1'b0}}};
        e.fm_data  = m_line[s][vw];               // old line leaves the cache
        n_evict++;
      end
      m_tag[s][vw]   = t;
      m_valid[s][vw] = 1'b1;
      m_mod[s][vw]   = fmod;
      m_line[s][vw]  = fline;
      mark_mru(s, vw);
    end else if (hw >= 0) begin
      e.result = HIT;
      n_hit++;
      if (op == RD_LU) begin
        e.line = m_line[s][hw];
      end else begin
        for (int b = 0; b < BE_WIDTH; b++) begin
          if (be[b]) m_line[s][hw][off[3:2]][8*b +: 8] = wdata[8*b +: 8];
        end
        m_mod[s][hw] = 1'b1;
      end
      mark_mru(s, hw);
    end else begin
      e.result   = MISS;                          // set untouched and far memory asked
      e.fm_valid = 1'b1;
      e.fm_op    = FILL_REQ_OP;
      e.fm_addr  = e.addr;
      n_miss++;
    end
    lu_valid         <= 1'b1;
    lu_op            <= op;
    lu_id            <= next_id;
    lu_addr          <= e.addr;
    lu_wdata         <= wdata;
    lu_byte_en       <= be;
    lu_fill_line     <= fline;
    lu_fill_modified <= fmod;
    exp_q.push_back(e);
    next_id++;
  endtask

  // ==========================================================================
  // response and far-memory compares
  // ==========================================================================
  task automatic check_rsp(lu_op_t op, lu_result_t result, logic [ID_WIDTH-1:0] id,
                           logic [ADDR_WIDTH-1:0] addr, line_t line, exp_t e);
    string        sig;
    logic [127:0] got;
    logic [127:0] exp;
    sig = "";
    if (result !== e.result) begin
      sig = "rsp_result";
      got = 128'(result);
      exp = 128'(e.result);
    end else if (op !== e.op) begin
      sig = "rsp_op";
      got = 128'(op);
      exp = 128'(e.op);
    end else if (id !== e.id) begin
      sig = "rsp_id";
      got = 128'(id);
      exp = 128'(e.id);
    end else if (addr !== e.addr) begin
      sig = "rsp_addr";
      got = 128'(addr);
      exp = 128'(e.addr);
    end else if (line !== e.line) begin
      sig = "rsp_line";
      got = line;
      exp = e.line;
    end
    if (sig != "") begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h (lookup id %0d)", sig, got, exp, e.id);
      $display("TESTS FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_fm(logic valid, fm_op_t op, logic [ADDR_WIDTH-1:0] addr,
                          logic [ID_WIDTH-1:0] id, line_t data, exp_t e);
    string        sig;
    logic [127:0] got;
    logic [127:0] exp;
    sig = "";
    if (valid !== e.fm_valid) begin
      sig = "fm_valid";
      got = 128'(valid);
      exp = 128'(e.fm_valid);
    end else if (e.fm_valid && op !== e.fm_op) begin
      sig = "fm_op";
      got = 128'(op);
      exp = 128'(e.fm_op);
    end else if (e.fm_valid && addr !== e.fm_addr) begin
      sig = "fm_addr";
      got = 128'(addr);
      exp = 128'(e.fm_addr);
    end else if (e.fm_valid && id !== e.id) begin
      sig = "fm_id";
      got = 128'(id);
      exp = 128'(e.id);
    end else if (e.fm_valid && data !== e.fm_data) begin
      sig = "fm_data";
      got = data;
      exp = e.fm_data;
    end
    if (sig != "") begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h (lookup id %0d)", sig, got, exp, e.id);
      $display("TESTS FAILED");
      $fatal(1, "far-memory mismatch");
    end
  endtask

  // ==========================================================================
  // output checks on the falling edge and cycle limit on the rising edge
  // ==========================================================================
  always @(negedge clk) begin : check_outputs
    exp_t head;
    if (!rst && rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("response id %0d arrived with no lookup outstanding", rsp_id);
        $display("TESTS FAILED");
        $fatal(1, "unexpected response");
      end else begin
        head = exp_q.pop_front();
        if (cycle_cnt != head.due) begin
          $display("response id %0d came at cycle %0d, due at %0d", rsp_id, cycle_cnt, head.due);
          $display("TESTS FAILED");
          $fatal(1, "wrong latency");
        end
        check_rsp(rsp_op, rsp_result, rsp_id, rsp_addr, rsp_line, head);
        check_fm(fm_valid, fm_op, fm_addr, fm_id, fm_data, head);
        rsp_cnt++;
      end
    end else if (!rst && exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
      $display("no response for lookup id %0d at cycle %0d", exp_q[0].id, cycle_cnt);
      $display("TESTS FAILED");
      $fatal(1, "missing response");
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    int issued;
    void'($urandom(SEED));
    rst              = 1'b1;
    lu_valid         = 1'b0;
    lu_op            = RD_LU;
    lu_id            = '0;
    lu_addr          = '0;
    lu_wdata         = '0;
    lu_byte_en       = '0;
    lu_fill_line     = '0;
    lu_fill_modified = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_mru[s]   = '0;
      m_mod[s]   = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w]  = '0;
        m_line[s][w] = '0;   // line RAM clears on reset too
      end
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    issued = 0;
    while (issued < NUM_LOOKUPS) begin
      @(posedge clk);
      if ($urandom % 4 == 0) begin
        lu_valid <= 1'b0;   // idle gap
      end else begin
        issue_lookup();
        issued++;
      end
    end
    @(posedge clk);
    lu_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);   // drain the pipe under the cycle limit
    @(posedge clk);
    $display("responses %0d, hits %0d, misses %0d, fills %0d, dirty evicts %0d",
             rsp_cnt, n_hit, n_miss, n_fill, n_evict);
    if (n_hit != 0 && n_miss != 0 && n_fill != 0 && n_evict != 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("the random lookups never covered every hit, miss, fill and evict case");
      $display("TESTS FAILED");
      $fatal(1, "stimulus coverage");
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_pipe_top.sv
`default_nettype none

module cache_pipe_top (
  input  wire                              clk,
  input  wire                              rst,
  // lookup in
  input  wire                              lu_valid,
  input  var  cache_pkg::lu_op_t           lu_op,
  input  wire [cache_pkg::ID_WIDTH-1:0]    lu_id,
  input  wire [cache_pkg::ADDR_WIDTH-1:0]  lu_addr,
  input  wire [cache_pkg::WORD_WIDTH-1:0]  lu_wdata,
  input  wire [cache_pkg::BE_WIDTH-1:0]    lu_byte_en,
  input  var  cache_pkg::line_t            lu_fill_line,
  input  wire                              lu_fill_modified,
  // response, two cycles after the lookup
  output logic                             rsp_valid,
  output cache_pkg::lu_op_t                rsp_op,
  output cache_pkg::lu_result_t            rsp_result,
  output logic [cache_pkg::ID_WIDTH-1:0]   rsp_id,
  output logic [cache_pkg::ADDR_WIDTH-1:0] rsp_addr,
  output cache_pkg::line_t                 rsp_line,
  // far memory, same cycle as the response
  output logic                             fm_valid,
  output cache_pkg::fm_op_t                fm_op,
  output logic [cache_pkg::ADDR_WIDTH-1:0] fm_addr,
  output logic [cache_pkg::ID_WIDTH-1:0]   fm_id,
  output cache_pkg::line_t                 fm_data
);
  import cache_pkg::*;

  pipe_t q2_pipe;   // q2 lookup with hit and victim results

  set_if u_set_if ();

  set_stage u_set_stage (
    .clk              (clk),
    .rst              (rst),
    .lu_valid         (lu_valid),
    .lu_op            (lu_op),
    .lu_id            (lu_id),
    .lu_addr          (lu_addr),
    .lu_wdata         (lu_wdata),
    .lu_byte_en       (lu_byte_en),
    .lu_fill_line     (lu_fill_line),
    .lu_fill_modified (lu_fill_modified),
    .set_bus          (u_set_if.stage),
    .q2_pipe          (q2_pipe)
  );

  hit_detect u_hit_detect (
    .set_bus (u_set_if.hit)
  );

  victim_select u_victim_select (
    .set_bus (u_set_if.victim)
  );

  data_stage u_data_stage (
    .clk        (clk),
    .rst        (rst),
    .q2_pipe    (q2_pipe),
    .rsp_valid  (rsp_valid),
    .rsp_op     (rsp_op),
    .rsp_result (rsp_result),
    .rsp_id     (rsp_id),
    .rsp_addr   (rsp_addr),
    .rsp_line   (rsp_line),
    .fm_valid   (fm_valid),
    .fm_op      (fm_op),
    .fm_addr    (fm_addr),
    .fm_id      (fm_id),
    .fm_data    (fm_data)
  );

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // ==========================================================================
  // cache geometry
  // ==========================================================================
  localparam int NUM_WAYS       = 4;
  localparam int WAY_WIDTH      = 2;
  localparam int NUM_SETS       = 16;
  localparam int SET_WIDTH      = 4;
  localparam int WORD_WIDTH     = 32;
  localparam int LINE_WORDS     = 4;
  localparam int ADDR_WIDTH     = 32;
  localparam int OFFSET_WIDTH   = 4;
  localparam int TAG_WIDTH      = ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH;  // 24
  localparam int ID_WIDTH       = 4;                                      // lookup id
  localparam int BE_WIDTH       = WORD_WIDTH / 8;                         // byte enables per word
  localparam int DADDR_WIDTH    = SET_WIDTH + WAY_WIDTH;                  // data array index
  localparam int WORD_SEL_WIDTH = $clog2(LINE_WORDS);
  localparam int BYTE_SEL_WIDTH = OFFSET_WIDTH - WORD_SEL_WIDTH;          // byte within word

  typedef enum logic [1:0] {RD_LU, WR_LU, FILL_LU} lu_op_t;
  typedef enum logic [1:0] {NO_RSP, HIT, MISS, FILL} lu_result_t;
  typedef enum logic {FILL_REQ_OP, DIRTY_EVICT_OP} fm_op_t;

  typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t;  // word 0 in the low bits
  typedef logic [NUM_WAYS-1:0] way_vec_t;

  // one tag array entry, a whole set
  typedef struct packed {
    way_vec_t                           valid;
    way_vec_t                           mru;
    way_vec_t                           modified;
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags;
  } set_entry_t;

  // lookup as it moves from q1 down to q3
  typedef struct packed {
    logic                      valid;
    lu_op_t                    op;
    logic [ID_WIDTH-1:0]       id;
    logic [TAG_WIDTH-1:0]      tag;
    logic [SET_WIDTH-1:0]      set_idx;
    logic [OFFSET_WIDTH-1:0]   offset;
    logic [WORD_WIDTH-1:0]     wdata;         // write word
    logic [BE_WIDTH-1:0]       byte_en;
    line_t                     fill_line;
    logic                      fill_modified;
    logic                      hit;           // filled in at q2
    logic [DADDR_WIDTH-1:0]    data_addr;     // {set, way}, filled in at q2
    logic                      dirty_evict;   // fill over a modified way
    logic [TAG_WIDTH-1:0]      victim_tag;    // tag of the way being replaced
  } pipe_t;

endpackage

`default_nettype wire

// File: verilog/data_stage.sv
`default_nettype none

module data_stage (
  input  wire                              clk,
  input  wire                              rst,
  input  var  cache_pkg::pipe_t            q2_pipe,
  output logic                             rsp_valid,
  output cache_pkg::lu_op_t                rsp_op,
  output cache_pkg::lu_result_t            rsp_result,
  output logic [cache_pkg::ID_WIDTH-1:0]   rsp_id,
  output logic [cache_pkg::ADDR_WIDTH-1:0] rsp_addr,
  output cache_pkg::line_t                 rsp_line,
  output logic                             fm_valid,
  output cache_pkg::fm_op_t                fm_op,
  output logic [cache_pkg::ADDR_WIDTH-1:0] fm_addr,
  output logic [cache_pkg::ID_WIDTH-1:0]   fm_id,
  output cache_pkg::line_t                 fm_data
);
  import cache_pkg::*;

  pipe_t                     q3_pipe;
  line_t                     ram_line_q3;     // data array read data
  line_t                     line_q3;         // after the q4 bypass
  line_t                     merged_q3;       // line with the write word merged in
  logic [WORD_SEL_WIDTH-1:0] word_sel_q3;
  logic                      is_fill_q3;
  logic                      line_wr_en_q3;
  line_t                     line_wr_data_q3;
  logic                      line_wr_en_q4;   // copy of the last line write
  logic [DADDR_WIDTH-1:0]    line_wr_addr_q4;
  line_t                     line_wr_data_q4;

  always_ff @(posedge clk) begin
    q3_pipe <= q2_pipe;
    if (rst) q3_pipe.valid <= 1'b0;
  end

  line_ram #(
    .DEPTH   (NUM_SETS * NUM_WAYS),
    .entry_t (line_t)
  ) u_data_ram (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (q2_pipe.valid),        // read at the q2 edge, data in q3
    .rd_index (q2_pipe.data_addr),
    .wr_en    (line_wr_en_q3),
    .wr_index (q3_pipe.data_addr),
    .wr_entry (line_wr_data_q3),
    .rd_entry (ram_line_q3)
  );

  // ==========================================================================
  // q3, line bypass and write merge
  // ==========================================================================
  assign line_q3 = (line_wr_en_q4 && (line_wr_addr_q4 == q3_pipe.data_addr)) ?
                   line_wr_data_q4 : ram_line_q3;   // write from the edge the read left

  assign word_sel_q3 = q3_pipe.offset[OFFSET_WIDTH-1:BYTE_SEL_WIDTH];
  assign is_fill_q3  = (q3_pipe.op == FILL_LU);

  always_comb begin
    merged_q3 = line_q3;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (q3_pipe.byte_en[b]) merged_q3[word_sel_q3][8*b +: 8] = q3_pipe.wdata[8*b +: 8];
    end
  end

  // only fills and write hits touch the array
  assign line_wr_en_q3   = q3_pipe.valid && (is_fill_q3 || ((q3_pipe.op == WR_LU) && q3_pipe.hit));
  assign line_wr_data_q3 = is_fill_q3 ? q3_pipe.fill_line : merged_q3;

  always_ff @(posedge clk) begin
    line_wr_addr_q4 <= q3_pipe.data_addr;
    line_wr_data_q4 <= line_wr_data_q3;
    if (rst) line_wr_en_q4 <= 1'b0;
    else     line_wr_en_q4 <= line_wr_en_q3;
  end

  // ==========================================================================
  // response and far-memory request
  // ==========================================================================
  assign rsp_valid  = q3_pipe.valid;
  assign rsp_op     = q3_pipe.op;
  assign rsp_id     = q3_pipe.id;
  assign rsp_addr   = {q3_pipe.tag, q3_pipe.set_idx, q3_pipe.offset};
  assign rsp_result = !q3_pipe.valid ? NO_RSP :
                      is_fill_q3     ? FILL   :
                      q3_pipe.hit    ? HIT    : MISS;
  assign rsp_line   = is_fill_q3                                ? q3_pipe.fill_line :
                      ((q3_pipe.op == RD_LU) && q3_pipe.hit)    ? line_q3           : '0;

  always_comb begin
    fm_valid = 1'b0;
    fm_op    = FILL_REQ_OP;
    fm_addr  = '0;
    fm_id    = q3_pipe.id;
    fm_data  = '0;
    if (q3_pipe.valid && is_fill_q3 && q3_pipe.dirty_evict) begin
      fm_valid = 1'b1;
      fm_op    = DIRTY_EVICT_OP;
      fm_addr  = {q3_pipe.victim_tag, q3_pipe.set_idx, {OFFSET_WIDTH{1'b0}}};  // line aligned
      fm_data  = line_q3;                                         // old line before the fill
    end else if (q3_pipe.valid && !is_fill_q3 && !q3_pipe.hit) begin
      fm_valid = 1'b1;                                            // read or write miss
      fm_op    = FILL_REQ_OP;
      fm_addr  = {q3_pipe.tag, q3_pipe.set_idx, q3_pipe.offset};
    end
  end

endmodule

`default_nettype wire

// File: verilog/hit_detect.sv
`default_nettype none

module hit_detect (
  set_if.hit set_bus
);
  import cache_pkg::*;

  // ==========================================================================
  // tag compare per way
  // ==========================================================================
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      set_bus.way_hit[w] = (set_bus.entry.tags[w] == set_bus.tag) &&
                           set_bus.entry.valid[w] &&
                           set_bus.valid;               // idle slot never hits
    end
  end

  // encode the hit, at most one way can match
  always_comb begin
    set_bus.hit_way = '0;                             // miss encodes as way 0
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (set_bus.way_hit[w]) set_bus.hit_way = WAY_WIDTH'(w);
    end
  end

endmodule

`default_nettype wire

// File: verilog/line_ram.sv
`default_nettype none

module line_ram #(
  parameter int  DEPTH   = 16,
  parameter type entry_t = logic [7:0]
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     rd_en,
  input  wire [$clog2(DEPTH)-1:0] rd_index,
  input  wire                     wr_en,
  input  wire [$clog2(DEPTH)-1:0] wr_index,
  input  var  entry_t             wr_entry,
  output entry_t                  rd_entry   // valid one cycle after rd_en
);

  entry_t mem [DEPTH];

  // write port, reset wipes the array so every way starts invalid
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) mem[i] <= '0;
    end else if (wr_en) begin
      mem[wr_index] <= wr_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) rd_entry <= mem[rd_index];  // same-entry write returns old data
  end

endmodule

`default_nettype wire

// File: verilog/set_if.sv
`default_nettype none

interface set_if;
  import cache_pkg::*;

  set_entry_t           entry;         // set state after the q3 bypass
  logic [TAG_WIDTH-1:0] tag;           // q2 lookup tag
  logic                 valid;         // q2 lookup valid
  way_vec_t             way_hit;       // one-hot, zero on miss
  logic [WAY_WIDTH-1:0] hit_way;
  way_vec_t             way_victim;    // one-hot fill candidate
  logic [WAY_WIDTH-1:0] victim_way;
  logic                 victim_dirty;  // candidate holds a modified line

  modport stage (output entry, tag, valid,
                 input  way_hit, hit_way, way_victim, victim_way, victim_dirty);

  modport hit (input  entry, tag, valid,
               output way_hit, hit_way);

  modport victim (input  entry,
                  output way_victim, victim_way, victim_dirty);

endinterface

`default_nettype wire

// File: verilog/set_stage.sv
`default_nettype none

module set_stage (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 lu_valid,
  input  var  cache_pkg::lu_op_t              lu_op,
  input  wire [cache_pkg::ID_WIDTH-1:0]       lu_id,
  input  wire [cache_pkg::ADDR_WIDTH-1:0]     lu_addr,
  input  wire [cache_pkg::WORD_WIDTH-1:0]     lu_wdata,
  input  wire [cache_pkg::BE_WIDTH-1:0]       lu_byte_en,
  input  var  cache_pkg::line_t               lu_fill_line,
  input  wire                                 lu_fill_modified,
  set_if.stage                                set_bus,
  output cache_pkg::pipe_t                    q2_pipe
);
  import cache_pkg::*;

  pipe_t                q1_next;
  pipe_t                q1_pipe;
  pipe_t                q2_reg;          // q2 lookup before the set results are added
  set_entry_t           ram_entry_q2;    // tag array read data
  set_entry_t           entry_q2;        // after the bypass
  set_entry_t           upd_entry_q2;    // set state written back
  logic                 set_hazard_q2;
  logic                 hit_q2;
  logic                 set_wr_en_q3;    // copy of the last set write
  logic [SET_WIDTH-1:0] set_wr_set_q3;
  set_entry_t           set_wr_entry_q3;

  // ==========================================================================
  // q1, split the address and issue the tag array read
  // ==========================================================================
  always_comb begin
    q1_next               = '0;
    q1_next.valid         = lu_valid;
    q1_next.op            = lu_op;
    q1_next.id            = lu_id;
    q1_next.tag           = lu_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    q1_next.set_idx       = lu_addr[OFFSET_WIDTH +: SET_WIDTH];
    q1_next.offset        = lu_addr[OFFSET_WIDTH-1:0];
    q1_next.wdata         = lu_wdata;
    q1_next.byte_en       = lu_byte_en;
    q1_next.fill_line     = lu_fill_line;
    q1_next.fill_modified = lu_fill_modified && (lu_op == FILL_LU);
  end

  always_ff @(posedge clk) begin
    q1_pipe <= q1_next;
    q2_reg  <= q1_pipe;
    if (rst) begin
      q1_pipe.valid <= 1'b0;
      q2_reg.valid  <= 1'b0;
    end
  end

  line_ram #(
    .DEPTH   (NUM_SETS),
    .entry_t (set_entry_t)
  ) u_tag_ram (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (q1_pipe.valid),
    .rd_index (q1_pipe.set_idx),
    .wr_en    (q2_reg.valid),        // every lookup writes its set back
    .wr_index (q2_reg.set_idx),
    .wr_entry (upd_entry_q2),
    .rd_entry (ram_entry_q2)
  );

  // ==========================================================================
  // q2, set bypass, hit/victim results and set update
  // ==========================================================================
  // the set written at the q2 edge was missed by the read issued at that edge
  assign set_hazard_q2 = set_wr_en_q3 && q2_reg.valid && (set_wr_set_q3 == q2_reg.set_idx);
  assign entry_q2      = set_hazard_q2 ? set_wr_entry_q3 : ram_entry_q2;

  assign set_bus.entry = entry_q2;
  assign set_bus.tag   = q2_reg.tag;
  assign set_bus.valid = q2_reg.valid;
  assign hit_q2        = |set_bus.way_hit;

  always_comb begin
    upd_entry_q2 = entry_q2;                      // misses leave the set alone
    case (q2_reg.op)
      RD_LU: if (hit_q2) upd_entry_q2.mru = entry_q2.mru | set_bus.way_hit;
      WR_LU: begin
        if (hit_q2) begin
          upd_entry_q2.mru      = entry_q2.mru | set_bus.way_hit;
          upd_entry_q2.modified = entry_q2.modified | set_bus.way_hit;
        end
      end
      FILL_LU: begin
        upd_entry_q2.tags[set_bus.victim_way] = q2_reg.tag;
        upd_entry_q2.valid = entry_q2.valid | set_bus.way_victim;
        upd_entry_q2.mru   = entry_q2.mru | set_bus.way_victim;
        upd_entry_q2.modified = q2_reg.fill_modified ?
                                (entry_q2.modified | set_bus.way_victim) :
                                (entry_q2.modified & ~set_bus.way_victim);
      end
      default: ;
    endcase
    // every way MRU, restart with the newest way only
    if (&upd_entry_q2.mru) begin
      upd_entry_q2.mru = (q2_reg.op == FILL_LU) ? set_bus.way_victim : set_bus.way_hit;
    end
  end

  always_ff @(posedge clk) begin
    set_wr_set_q3   <= q2_reg.set_idx;
    set_wr_entry_q3 <= upd_entry_q2;
    if (rst) set_wr_en_q3 <= 1'b0;
    else     set_wr_en_q3 <= q2_reg.valid;
  end

  always_comb begin
    q2_pipe             = q2_reg;
    q2_pipe.hit         = hit_q2;
    q2_pipe.data_addr   = {q2_reg.set_idx,
                           (q2_reg.op == FILL_LU) ? set_bus.victim_way : set_bus.hit_way};
    q2_pipe.dirty_evict = (q2_reg.op == FILL_LU) && set_bus.victim_dirty;
    q2_pipe.victim_tag  = entry_q2.tags[set_bus.victim_way];   // pre-fill tag
  end

endmodule

`default_nettype wire

// File: verilog/victim_select.sv
`default_nettype none

module victim_select (
  set_if.victim set_bus
);
  import cache_pkg::*;

  way_vec_t free_ways;   // invalid ways
  way_vec_t lru_ways;    // ways without MRU
  way_vec_t first_free;
  way_vec_t first_lru;

  assign free_ways = ~set_bus.entry.valid;
  assign lru_ways  = ~set_bus.entry.mru;

  // lowest index wins, so scan down and let the last hit stick
  always_comb begin
    first_free = '0;
    first_lru  = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (free_ways[w]) begin
        first_free    = '0;
        first_free[w] = 1'b1;
      end
      if (lru_ways[w]) begin
        first_lru    = '0;
        first_lru[w] = 1'b1;
      end
    end
  end

  // free way first, then non-MRU; all-MRU never survives a set write
  assign set_bus.way_victim = (|free_ways) ? first_free :
                              (|lru_ways)  ? first_lru  :
                                             way_vec_t'(1);

  always_comb begin
    set_bus.victim_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (set_bus.way_victim[w]) set_bus.victim_way = WAY_WIDTH'(w);
    end
  end

  assign set_bus.victim_dirty = |(set_bus.entry.valid & set_bus.entry.modified &
                                  set_bus.way_victim);   // evict needed

endmodule

`default_nettype wire
